/* uart_pkg.sv */
`default_nettype none

package uart_pkg;

    // ------------------------------
    // Register map
    // ------------------------------
    localparam logic [3:0] ADDR_DATA    = 4'h0;
    localparam logic [3:0] ADDR_STATUS  = 4'h4;
    localparam logic [3:0] ADDR_DIVISOR = 4'h8;

    // AXI response codes
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // ------------------------------
    // Baud and framing
    // ------------------------------
    localparam int DIV_WIDTH = 16;
    localparam logic [DIV_WIDTH-1:0] DIV_RESET = 16'd4;

    // Ticks per bit
    localparam int OVERSAMPLE = 8;

    // ------------------------------
    // FIFOs
    // ------------------------------
    localparam int FIFO_DEPTH = 8;
    localparam int FIFO_PTR_WIDTH = $clog2(FIFO_DEPTH);

    // Receive FIFO payload
    typedef struct packed {
        logic       brk;
        logic [7:0] data;
    } rx_entry_t;

    // STATUS bit positions
    localparam logic [4:0] RX_EMPTY    = 5'd0;
    localparam logic [4:0] TX_FULL     = 5'd1;
    localparam logic [4:0] TX_BUSY     = 5'd2;
    localparam logic [4:0] FRAMING_ERR = 5'd3;
    localparam logic [4:0] RX_OVERRUN  = 5'd4;

endpackage

`default_nettype wire

/* uart_baud_gen.sv */
`default_nettype none

module uart_baud_gen import uart_pkg::*; (
    input  wire                 clk,
    input  wire                 reset,
    input  wire [DIV_WIDTH-1:0] divisor,
    output logic                tick
);

    logic [DIV_WIDTH-1:0] count;

    // Down counter with a tick on reload
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count <= '0;
            tick  <= 1'b0;
        end else if (count == '0) begin
            count <= divisor - 1'b1;
            tick  <= 1'b1;
        end else begin
            count <= count - 1'b1;
            tick  <= 1'b0;
        end
    end

    // Control side must never program a zero divisor
    divisor_nonzero: assert property (
        @(posedge clk) disable iff (reset) divisor != '0
    );

endmodule

`default_nettype wire

/* uart_rx.sv */
`default_nettype none

module uart_rx import uart_pkg::*; (
    input  wire       clk,
    input  wire       reset,
    input  wire       tick,
    input  wire       rxd,
    output rx_entry_t entry,
    output logic      push,
    output logic      framing_error
);

    typedef enum logic [1:0] {
        IDLE,
        RECEIVE,
        WAIT_HIGH
    } state_t;

    state_t     state;
    logic [3:0] sync;
    logic [2:0] phase;
    logic [3:0] bit_cnt;
    logic [7:0] shift;
    logic       rx_in;
    logic       start_edge;
    logic       sample;

    // Synchronizer idles high out of reset
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sync <= '1;
        end else begin
            sync <= {sync[2:0], rxd};
        end
    end

    assign rx_in      = sync[2];
    assign start_edge = (sync[3:2] == 2'b10);
    assign sample     = tick && (phase == 3'(OVERSAMPLE / 2)) && (state == RECEIVE);

    // ------------------------------
    // Frame control
    // ------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state         <= IDLE;
            phase         <= '0;
            bit_cnt       <= '0;
            push          <= 1'b0;
            framing_error <= 1'b0;
        end else begin
            push          <= 1'b0;
            framing_error <= 1'b0;
            case (state)
                IDLE: begin
                    phase   <= '0;
                    bit_cnt <= '0;
                    if (start_edge) begin
                        state <= RECEIVE;
                    end
                end
                RECEIVE: begin
                    if (tick) begin
                        phase <= phase + 3'd1;
                    end
                    if (sample) begin
                        if (bit_cnt == 4'd0 && rx_in) begin
                            // Start bit gone by mid-bit means a glitch
                            state <= IDLE;
                        end else if (bit_cnt == 4'd9) begin
                            if (rx_in) begin
                                push  <= 1'b1;
                                state <= IDLE;
                            end else begin
                                if (shift == 8'h00) begin
                                    push <= 1'b1;
                                end else begin
                                    framing_error <= 1'b1;
                                end
                                state <= WAIT_HIGH;
                            end
                        end else begin
                            bit_cnt <= bit_cnt + 4'd1;
                        end
                    end
                end
                default: begin
                    if (rx_in) begin
                        state <= IDLE;
                    end
                end
            endcase
        end
    end

    // Start bit goes in first and is pushed out by the 8 data bits
    always_ff @(posedge clk) begin
        if (sample) begin
            if (bit_cnt != 4'd9) begin
                shift <= {rx_in, shift[7:1]};
            end else begin
                entry.data <= shift;
                entry.brk  <= !rx_in;
            end
        end
    end

    push_xor_error: assert property (
        @(posedge clk) disable iff (reset) !(push && framing_error)
    );

endmodule

`default_nettype wire

/* uart_tx.sv */
`default_nettype none

module uart_tx import uart_pkg::*; (
    input  wire       clk,
    input  wire       reset,
    input  wire       tick,
    input  wire [7:0] data,
    input  wire       empty,
    output logic      pop,
    output logic      txd,
    output logic      busy
);

    logic [9:0] frame;
    logic [2:0] tick_cnt;
    logic [3:0] bit_cnt;

    // Load strobe doubles as the FIFO pop
    assign pop = tick && !busy && !empty;
    assign txd = frame[0];

    // ------------------------------
    // Frame shifter
    // ------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            frame    <= '1;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            busy     <= 1'b0;
        end else if (pop) begin
            // Stop, data LSB first, start
            frame    <= {1'b1, data, 1'b0};
            tick_cnt <= '0;
            bit_cnt  <= '0;
            busy     <= 1'b1;
        end else if (busy && tick) begin
            tick_cnt <= tick_cnt + 3'd1;
            if (tick_cnt == 3'(OVERSAMPLE - 1)) begin
                // Ones fill in behind, so the line idles high after the stop bit
                frame <= {1'b1, frame[9:1]};
                if (bit_cnt == 4'd9) begin
                    busy <= 1'b0;
                end else begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end
        end
    end

    // Line stays high whenever no frame is in flight
    idle_high: assert property (
        @(posedge clk) disable iff (reset) !busy |-> txd
    );

endmodule

`default_nettype wire

/* uart_fifo.sv */
`default_nettype none

module uart_fifo import uart_pkg::*; #(
    parameter type item_t = logic [7:0]
) (
    input  wire   clk,
    input  wire   reset,
    input  wire   push,
    input  item_t push_item,
    input  wire   pop,
    output item_t head,
    output logic  empty,
    output logic  full
);

    item_t mem [FIFO_DEPTH];

    // Pointers carry one extra wrap bit
    logic [FIFO_PTR_WIDTH:0] wr_ptr;
    logic [FIFO_PTR_WIDTH:0] rd_ptr;
    logic [FIFO_PTR_WIDTH:0] occupancy;
    logic                    do_push;
    logic                    do_pop;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[FIFO_PTR_WIDTH] != rd_ptr[FIFO_PTR_WIDTH]) &&
                   (wr_ptr[FIFO_PTR_WIDTH-1:0] == rd_ptr[FIFO_PTR_WIDTH-1:0]);

    assign do_push   = push && !full;
    assign do_pop    = pop && !empty;
    assign occupancy = wr_ptr - rd_ptr;

    assign head = mem[rd_ptr[FIFO_PTR_WIDTH-1:0]];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr[FIFO_PTR_WIDTH-1:0]] <= push_item;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    occupancy_bound: assert property (
        @(posedge clk) disable iff (reset) occupancy <= (FIFO_PTR_WIDTH + 1)'(FIFO_DEPTH)
    );

endmodule

`default_nettype wire

/* uart_axil_ctrl.sv */
`default_nettype none

module uart_axil_ctrl import uart_pkg::*; (
    input  wire                  clk,
    input  wire                  reset,

    input  wire [3:0]            awaddr,
    input  wire                  awvalid,
    output logic                 awready,
    input  wire [31:0]           wdata,
    input  wire                  wvalid,
    output logic                 wready,
    output logic [1:0]           bresp,
    output logic                 bvalid,
    input  wire                  bready,
    input  wire [3:0]            araddr,
    input  wire                  arvalid,
    output logic                 arready,
    output logic [31:0]          rdata,
    output logic [1:0]           rresp,
    output logic                 rvalid,
    input  wire                  rready,

    output logic                 tx_push,
    output logic [7:0]           tx_byte,
    input  wire                  tx_full,
    input  wire                  tx_busy,
    input  rx_entry_t            rx_head,
    input  wire                  rx_empty,
    input  wire                  rx_full,
    output logic                 rx_pop,
    input  wire                  rx_push,
    input  wire                  framing_error,
    output logic [DIV_WIDTH-1:0] divisor
);

    logic        wr_fire;
    logic        rd_fire;
    logic [1:0]  wr_resp;
    logic [1:0]  rd_resp;
    logic [31:0] rd_word;
    logic [31:0] status_word;
    logic        framing_err_q;
    logic        overrun_q;

    // ------------------------------
    // Handshakes
    // ------------------------------
    // Address and data are taken together
    assign awready = awvalid && wvalid && !bvalid;
    assign wready  = awvalid && wvalid && !bvalid;
    assign arready = arvalid && !rvalid;
    assign wr_fire = awready;
    assign rd_fire = arready;

    assign tx_push = wr_fire && (awaddr == ADDR_DATA) && !tx_full;
    assign tx_byte = wdata[7:0];
    assign rx_pop  = rd_fire && (araddr == ADDR_DATA) && !rx_empty;

    always_comb begin
        status_word              = '0;
        status_word[RX_EMPTY]    = rx_empty;
        status_word[TX_FULL]     = tx_full;
        status_word[TX_BUSY]     = tx_busy;
        status_word[FRAMING_ERR] = framing_err_q;
        status_word[RX_OVERRUN]  = overrun_q;
    end

    always_comb begin
        wr_resp = RESP_OKAY;
        case (awaddr)
            ADDR_DATA:    wr_resp = tx_full ? RESP_SLVERR : RESP_OKAY;
            ADDR_STATUS:  wr_resp = RESP_OKAY;
            ADDR_DIVISOR: wr_resp = RESP_OKAY;
            default:      wr_resp = RESP_SLVERR;
        endcase
    end

    always_comb begin
        rd_word = '0;
        rd_resp = RESP_OKAY;
        case (araddr)
            ADDR_DATA: begin
                if (!rx_empty) begin
                    rd_word[$bits(rx_entry_t)-1:0] = rx_head;
                end
            end
            ADDR_STATUS:  rd_word = status_word;
            ADDR_DIVISOR: rd_word[DIV_WIDTH-1:0] = divisor;
            default:      rd_resp = RESP_SLVERR;
        endcase
    end

    // ------------------------------
    // Registers and channel state
    // ------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            bvalid        <= 1'b0;
            rvalid        <= 1'b0;
            divisor       <= DIV_RESET;
            framing_err_q <= 1'b0;
            overrun_q     <= 1'b0;
        end else begin
            if (wr_fire) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            if (rd_fire) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end

            // A zero divisor would stop the tick, so it is not taken
            if (wr_fire && awaddr == ADDR_DIVISOR && wdata[DIV_WIDTH-1:0] != '0) begin
                divisor <= wdata[DIV_WIDTH-1:0];
            end

            // Write one to clear
            if (wr_fire && awaddr == ADDR_STATUS) begin
                if (wdata[FRAMING_ERR]) begin
                    framing_err_q <= 1'b0;
                end
                if (wdata[RX_OVERRUN]) begin
                    overrun_q <= 1'b0;
                end
            end
            // A new event wins over a clear
            if (framing_error) begin
                framing_err_q <= 1'b1;
            end
            if (rx_push && rx_full) begin
                overrun_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            bresp <= wr_resp;
        end
        if (rd_fire) begin
            rdata <= rd_word;
            rresp <= rd_resp;
        end
    end

    bvalid_held: assert property (
        @(posedge clk) disable iff (reset) bvalid && !bready |=> bvalid && $stable(bresp)
    );

endmodule

`default_nettype wire

/* uart_top.sv */
`default_nettype none

module uart_top import uart_pkg::*; (
    input  wire         clk,
    input  wire         reset,

    input  wire [3:0]   awaddr,
    input  wire         awvalid,
    output logic        awready,
    input  wire [31:0]  wdata,
    input  wire         wvalid,
    output logic        wready,
    output logic [1:0]  bresp,
    output logic        bvalid,
    input  wire         bready,
    input  wire [3:0]   araddr,
    input  wire         arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rvalid,
    input  wire         rready,

    input  wire         rxd,
    output logic        txd
);

    logic                 tick;
    logic [DIV_WIDTH-1:0] divisor;
    rx_entry_t            rx_entry;
    rx_entry_t            rx_head;
    logic                 rx_push;
    logic                 rx_pop;
    logic                 rx_empty;
    logic                 rx_full;
    logic                 framing_error;
    logic                 tx_push;
    logic [7:0]           tx_byte;
    logic [7:0]           tx_head;
    logic                 tx_pop;
    logic                 tx_empty;
    logic                 tx_full;
    logic                 tx_busy;

    uart_axil_ctrl ctrl (
        .clk           (clk),
        .reset         (reset),
        .awaddr        (awaddr),
        .awvalid       (awvalid),
        .awready       (awready),
        .wdata         (wdata),
        .wvalid        (wvalid),
        .wready        (wready),
        .bresp         (bresp),
        .bvalid        (bvalid),
        .bready        (bready),
        .araddr        (araddr),
        .arvalid       (arvalid),
        .arready       (arready),
        .rdata         (rdata),
        .rresp         (rresp),
        .rvalid        (rvalid),
        .rready        (rready),
        .tx_push       (tx_push),
        .tx_byte       (tx_byte),
        .tx_full       (tx_full),
        .tx_busy       (tx_busy),
        .rx_head       (rx_head),
        .rx_empty      (rx_empty),
        .rx_full       (rx_full),
        .rx_pop        (rx_pop),
        .rx_push       (rx_push),
        .framing_error (framing_error),
        .divisor       (divisor)
    );

    uart_baud_gen baud_gen (
        .clk     (clk),
        .reset   (reset),
        .divisor (divisor),
        .tick    (tick)
    );

    uart_rx rx (
        .clk           (clk),
        .reset         (reset),
        .tick          (tick),
        .rxd           (rxd),
        .entry         (rx_entry),
        .push          (rx_push),
        .framing_error (framing_error)
    );

    uart_fifo #(.item_t(rx_entry_t)) rx_fifo (
        .clk       (clk),
        .reset     (reset),
        .push      (rx_push),
        .push_item (rx_entry),
        .pop       (rx_pop),
        .head      (rx_head),
        .empty     (rx_empty),
        .full      (rx_full)
    );

    uart_fifo #(.item_t(logic [7:0])) tx_fifo (
        .clk       (clk),
        .reset     (reset),
        .push      (tx_push),
        .push_item (tx_byte),
        .pop       (tx_pop),
        .head      (tx_head),
        .empty     (tx_empty),
        .full      (tx_full)
    );

    uart_tx tx (
        .clk   (clk),
        .reset (reset),
        .tick  (tick),
        .data  (tx_head),
        .empty (tx_empty),
        .pop   (tx_pop),
        .txd   (txd),
        .busy  (tx_busy)
    );

endmodule

`default_nettype wire

/* tb_uart_top.sv */
`default_nettype none

module tb_uart_top import uart_pkg::*; ();

    localparam int     CLK_PERIOD  = 100;
    localparam int     DRIVE_DELAY = 10;
    localparam int     MAX_DIV     = 6;
    localparam longint FRAME_TIME  = 10 * OVERSAMPLE * MAX_DIV * CLK_PERIOD;
    localparam longint WD_MARGIN   = 200000;

    // Test kinds
    localparam int K_WRITE = 0;
    localparam int K_READ  = 1;
    localparam int K_RESP  = 2;
    localparam int K_RX    = 3;
    localparam int K_TX    = 4;
    localparam int K_WAIT  = 5;

    logic        clk;
    logic        reset;
    logic [3:0]  awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [3:0]  araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;
    logic        rxd;
    logic        txd;

    string       test_name[$];
    int          test_kind[$];
    logic [3:0]  test_addr[$];
    logic [7:0]  test_data[$];
    logic        test_stop[$];
    logic [31:0] test_expect[$];

    logic [7:0]  txd_bytes[$];
    int          bit_clocks;
    int unsigned lcg_state;
    int          fail_count;
    int          tests_done;
    bit          table_ready = 1'b0;

    uart_top uut (
        .clk     (clk),
        .reset   (reset),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .rxd     (rxd),
        .txd     (txd)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ------------------------------
    // Helpers
    // ------------------------------
    function automatic int unsigned next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // Lands a small delay after a rising edge
    task automatic wait_clocks(input int n);
        repeat (n) begin
            @(posedge clk);
            #(DRIVE_DELAY);
        end
    endtask

    task automatic bus_write(input logic [3:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
        int delay;
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        @(negedge clk);
        while (!(awready && wready)) begin
            @(negedge clk);
        end
        wait_clocks(1);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        delay = int'((next_random() >> 16) % 4);
        wait_clocks(delay);
        bready = 1'b1;
        @(negedge clk);
        while (!bvalid) begin
            @(negedge clk);
        end
        resp = bresp;
        wait_clocks(1);
        bready = 1'b0;
    endtask

    task automatic bus_read(input logic [3:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        int delay;
        araddr  = addr;
        arvalid = 1'b1;
        @(negedge clk);
        while (!arready) begin
            @(negedge clk);
        end
        wait_clocks(1);
        arvalid = 1'b0;
        delay = int'((next_random() >> 16) % 4);
        wait_clocks(delay);
        rready = 1'b1;
        @(negedge clk);
        while (!rvalid) begin
            @(negedge clk);
        end
        data = rdata;
        resp = rresp;
        wait_clocks(1);
        rready = 1'b0;
    endtask

    // Start, 8 data bits LSB first, stop, then one idle bit
    task automatic send_frame(input logic [7:0] data, input logic stop, input int bit_len);
        rxd = 1'b0;
        wait_clocks(bit_len);
        for (int i = 0; i < 8; i++) begin
            rxd = data[i];
            wait_clocks(bit_len);
        end
        rxd = stop;
        wait_clocks(bit_len);
        rxd = 1'b1;
        wait_clocks(bit_len);
    endtask

    task automatic add_test(input string name, input int kind, input logic [3:0] addr,
                            input logic [7:0] data, input logic stop,
                            input logic [31:0] expect_value);
        test_name.push_back(name);
        test_kind.push_back(kind);
        test_addr.push_back(addr);
        test_data.push_back(data);
        test_stop.push_back(stop);
        test_expect.push_back(expect_value);
    endtask

    // ------------------------------
    // Test table
    // ------------------------------
    task automatic build_table();
        add_test("reset divisor", K_READ, ADDR_DIVISOR, 8'h00, 1'b1, 32'(DIV_RESET));
        add_test("reset status", K_READ, ADDR_STATUS, 8'h00, 1'b1, 32'h01);
        add_test("set divisor", K_WRITE, ADDR_DIVISOR, 8'h06, 1'b1, 32'(RESP_OKAY));
        add_test("divisor readback", K_READ, ADDR_DIVISOR, 8'h00, 1'b1, 32'h06);
        add_test("tx write 55", K_WRITE, ADDR_DATA, 8'h55, 1'b1, 32'(RESP_OKAY));
        add_test("tx write a3", K_WRITE, ADDR_DATA, 8'ha3, 1'b1, 32'(RESP_OKAY));
        add_test("tx write 0f", K_WRITE, ADDR_DATA, 8'h0f, 1'b1, 32'(RESP_OKAY));
        add_test("txd byte 55", K_TX, ADDR_DATA, 8'h00, 1'b1, 32'h55);
        add_test("txd byte a3", K_TX, ADDR_DATA, 8'h00, 1'b1, 32'ha3);
        add_test("txd byte 0f", K_TX, ADDR_DATA, 8'h00, 1'b1, 32'h0f);
        add_test("rx frame 3c", K_RX, ADDR_DATA, 8'h3c, 1'b1, 32'h0);
        add_test("rx frame c5", K_RX, ADDR_DATA, 8'hc5, 1'b1, 32'h0);
        add_test("rx read 3c", K_READ, ADDR_DATA, 8'h00, 1'b1, 32'h03c);
        add_test("rx read c5", K_READ, ADDR_DATA, 8'h00, 1'b1, 32'h0c5);
        add_test("rx empty again", K_READ, ADDR_STATUS, 8'h00, 1'b1, 32'h01);
        add_test("rx read when empty", K_READ, ADDR_DATA, 8'h00, 1'b1, 32'h0);
        // Low stop bit gives a framing error and then a break
        add_test("bad stop frame 5a", K_RX, ADDR_DATA, 8'h5a, 1'b0, 32'h0);
        add_test("framing error set", K_READ, ADDR_STATUS, 8'h00, 1'b1, 32'h09);
        add_test("framing error clear", K_WRITE, ADDR_STATUS, 8'h08, 1'b1, 32'(RESP_OKAY));
        add_test("framing error gone", K_READ, ADDR_STATUS, 8'h00, 1'b1, 32'h01);
        add_test("break frame", K_RX, ADDR_DATA, 8'h00, 1'b0, 32'h0);
        add_test("break read", K_READ, ADDR_DATA, 8'h00, 1'b1, 32'h100);
        add_test("break drained", K_READ, ADDR_STATUS, 8'h00, 1'b1, 32'h01);
        // Transmit FIFO fill while the first byte is on the line
        add_test("tx start", K_WRITE, ADDR_DATA, 8'h11, 1'b1, 32'(RESP_OKAY));
        add_test("tx load wait", K_WAIT, ADDR_DATA, 8'd20, 1'b1, 32'h0);
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            add_test($sformatf("tx fill %0d", i), K_WRITE, ADDR_DATA, 8'(33 + i), 1'b1,
                     32'(RESP_OKAY));
        end
        add_test("tx write when full", K_WRITE, ADDR_DATA, 8'h29, 1'b1, 32'(RESP_SLVERR));
        add_test("status tx full", K_READ, ADDR_STATUS, 8'h00, 1'b1, 32'h07);
        add_test("txd byte 11", K_TX, ADDR_DATA, 8'h00, 1'b1, 32'h11);
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            add_test($sformatf("txd fill %0d", i), K_TX, ADDR_DATA, 8'h00, 1'b1, 32'(33 + i));
        end
        // One frame more than the receive FIFO holds
        for (int i = 0; i <= FIFO_DEPTH; i++) begin
            add_test($sformatf("rx frame %0d", i), K_RX, ADDR_DATA, 8'(49 + i), 1'b1, 32'h0);
        end
        add_test("overrun set", K_READ, ADDR_STATUS, 8'h00, 1'b1, 32'h10);
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            add_test($sformatf("rx read %0d", i), K_READ, ADDR_DATA, 8'h00, 1'b1, 32'(49 + i));
        end
        add_test("overrun drained", K_READ, ADDR_STATUS, 8'h00, 1'b1, 32'h11);
        add_test("overrun clear", K_WRITE, ADDR_STATUS, 8'h10, 1'b1, 32'(RESP_OKAY));
        add_test("overrun gone", K_READ, ADDR_STATUS, 8'h00, 1'b1, 32'h01);
        add_test("read bad address", K_RESP, 4'hc, 8'h00, 1'b1, 32'(RESP_SLVERR));
        add_test("write bad address", K_WRITE, 4'hc, 8'h00, 1'b1, 32'(RESP_SLVERR));
    endtask

    // ------------------------------
    // txd monitor
    // ------------------------------
    initial begin : txd_monitor
        logic [7:0] decoded;
        wait (reset == 1'b0);
        forever begin
            @(negedge txd);
            #(bit_clocks * CLK_PERIOD / 2);
            if (txd == 1'b0) begin
                for (int i = 0; i < 8; i++) begin
                    #(bit_clocks * CLK_PERIOD);
                    decoded[i] = txd;
                end
                #(bit_clocks * CLK_PERIOD);
                if (txd != 1'b1) begin
                    $display("Stop bit on txd was low after byte 0x%02h", decoded);
                    fail_count++;
                end
                txd_bytes.push_back(decoded);
            end
        end
    end

    initial begin : watchdog
        longint limit;
        wait (table_ready);
        limit = longint'(test_name.size()) * 12 * FRAME_TIME + WD_MARGIN;
        #(limit);
        $display("Watchdog expired after %0d of %0d tests", tests_done, test_name.size());
        $display("Simulation finished: FAIL");
        $finish;
    end

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin : main
        logic [1:0]  resp;
        logic [31:0] actual;
        bit          checked;
        int          fails_before;
        reset      = 1'b1;
        awaddr     = '0;
        awvalid    = 1'b0;
        wdata      = '0;
        wvalid     = 1'b0;
        bready     = 1'b0;
        araddr     = '0;
        arvalid    = 1'b0;
        rready     = 1'b0;
        rxd        = 1'b1;
        fail_count = 0;
        tests_done = 0;
        lcg_state  = 32'd35745;
        bit_clocks = int'(DIV_RESET) * OVERSAMPLE;
        build_table();
        table_ready = 1'b1;
        wait_clocks(2);
        reset = 1'b0;
        wait_clocks(2);

        for (int t = 0; t < test_name.size(); t++) begin
            actual       = '0;
            checked      = 1'b1;
            fails_before = fail_count;
            case (test_kind[t])
                K_WRITE: begin
                    bus_write(test_addr[t], {24'h0, test_data[t]}, resp);
                    actual = {30'h0, resp};
                    // Bit time follows an accepted divisor write
                    if (test_addr[t] == ADDR_DIVISOR && resp == RESP_OKAY) begin
                        bit_clocks = int'(test_data[t]) * OVERSAMPLE;
                    end
                end
                K_READ: begin
                    bus_read(test_addr[t], actual, resp);
                    if (resp !== RESP_OKAY) begin
                        $display("CHECK FAILED %s: expected response 0x%0h, actual 0x%0h",
                                 test_name[t], RESP_OKAY, resp);
                        fail_count++;
                    end
                end
                K_RESP: begin
                    bus_read(test_addr[t], actual, resp);
                    actual = {30'h0, resp};
                end
                K_RX: begin
                    send_frame(test_data[t], test_stop[t], bit_clocks);
                    checked = 1'b0;
                end
                K_TX: begin
                    while (txd_bytes.size() == 0) begin
                        @(posedge clk);
                    end
                    #(DRIVE_DELAY);
                    actual = {24'h0, txd_bytes.pop_front()};
                end
                default: begin
                    wait_clocks(int'(test_data[t]));
                    checked = 1'b0;
                end
            endcase
            if (checked && actual !== test_expect[t]) begin
                $display("CHECK FAILED %s: expected 0x%0h, actual 0x%0h",
                         test_name[t], test_expect[t], actual);
                fail_count++;
            end else if (fail_count == fails_before) begin
                $display("ok    %s", test_name[t]);
            end
            tests_done++;
        end

        if (txd_bytes.size() != 0) begin
            $display("%0d unexpected bytes were sent on txd", txd_bytes.size());
            fail_count++;
        end
        $display("Tests run: %0d, failures: %0d", tests_done, fail_count);
        if (fail_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
uart_pkg.sv
uart_baud_gen.sv
uart_rx.sv
uart_tx.sv
uart_fifo.sv
uart_axil_ctrl.sv
uart_top.sv
tb_uart_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the UART testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_uart_top -f src.f \
    || { echo "Verilator build failed"; exit 1; }
sim_output=$(./obj_dir/Vtb_uart_top)
echo "$sim_output"
echo "$sim_output" | grep -qx "Simulation finished: PASS" && exit 0 || exit 1
